// File: source/pad_dma_pkg.sv
// Shared constants, bus structs and FSM state encoding for the padding DMA
// AXI fields are fixed to single-beat 32-bit INCR transfers with all strobes set

package pad_dma_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BEAT_BYTES = 4;   // One word per beat

    // Constant AXI attributes tied off at the top level
    localparam logic [2:0] AXI_SIZE_WORD  = 3'($clog2(BEAT_BYTES));
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_LEN_SINGLE = 4'd0;
    localparam logic [BEAT_BYTES-1:0] AXI_STRB_ALL = {BEAT_BYTES{1'b1}};

    // Matrix dimension width, W up to 2**DIM_W - 2
    localparam int DIM_W_DEFAULT = 6;

    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_READ  = 3'd1,
        S_WRITE = 3'd2,
        S_NEXT  = 3'd3,
        S_DONE  = 3'd4
    } dma_state_e;

    // Address request, shared by AR and AW
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } addr_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic              last;
    } wbeat_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } rbeat_t;

endpackage

// File: source/pad_dma_fsm.sv
// Job sequencer: four reads then four writes per 2x2 block
// start_i and done_o are levels; a new job needs start_i low in between
`timescale 1ns/100ps

module pad_dma_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic last_elem_i,
    input  logic last_block_i,
    input  logic rd_done_i,
    input  logic wr_done_i,
    output logic done_o,
    output logic clear_o,
    output logic load_o,
    output logic step_elem_o,
    output logic step_block_o,
    output logic rd_go_o,
    output logic wr_go_o
);

    pad_dma_pkg::dma_state_e state_q;
    logic done_q;
    logic wait_q;      // Transfer issued, waiting for its done pulse
    logic job_start;

    assign job_start = (state_q == pad_dma_pkg::S_IDLE) && start_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= pad_dma_pkg::S_IDLE;
            done_q  <= 1'b1;
            wait_q  <= 1'b0;
        end else begin
            case (state_q)
                pad_dma_pkg::S_IDLE: begin
                    if (start_i) begin
                        state_q <= pad_dma_pkg::S_READ;
                        done_q  <= 1'b0;
                        wait_q  <= 1'b0;
                    end
                end
                pad_dma_pkg::S_READ: begin
                    if (rd_go_o)
                        wait_q <= 1'b1;
                    if (rd_done_i) begin
                        wait_q <= 1'b0;
                        if (last_elem_i)
                            state_q <= pad_dma_pkg::S_WRITE;
                    end
                end
                pad_dma_pkg::S_WRITE: begin
                    if (wr_go_o)
                        wait_q <= 1'b1;
                    if (wr_done_i) begin
                        wait_q <= 1'b0;
                        if (last_elem_i)
                            state_q <= pad_dma_pkg::S_NEXT;
                    end
                end
                pad_dma_pkg::S_NEXT: begin
                    if (last_block_i) begin
                        state_q <= pad_dma_pkg::S_DONE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= pad_dma_pkg::S_READ;
                    end
                end
                pad_dma_pkg::S_DONE: begin
                    if (!start_i)
                        state_q <= pad_dma_pkg::S_IDLE;   // Hold until start drops
                end
                default: state_q <= pad_dma_pkg::S_IDLE;
            endcase
        end
    end

    assign done_o  = done_q;
    assign clear_o = job_start;
    assign load_o  = job_start;

    // One go pulse per element, then wait
    assign rd_go_o = (state_q == pad_dma_pkg::S_READ) && !wait_q;
    assign wr_go_o = (state_q == pad_dma_pkg::S_WRITE) && !wait_q;

    assign step_elem_o  = ((state_q == pad_dma_pkg::S_READ) && rd_done_i) ||
                          ((state_q == pad_dma_pkg::S_WRITE) && wr_done_i);
    assign step_block_o = (state_q == pad_dma_pkg::S_NEXT) && !last_block_i;

endmodule

// File: source/block_walker.sv
// Walks the padded output in 2x2 blocks, row by row
// Assumes an even width so blocks tile the (W+2) x (W+2) output exactly
`timescale 1ns/100ps

module block_walker #(
    parameter int DIM_W = 6
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [DIM_W-1:0] width_i,
    input  logic             clear_i,
    input  logic             step_elem_i,
    input  logic             step_block_i,
    output logic [DIM_W-1:0] out_row_o,
    output logic [DIM_W-1:0] out_col_o,
    output logic [1:0]       elem_idx_o,
    output logic             last_elem_o,
    output logic             last_block_o
);

    logic [DIM_W-1:0] blk_row_q, blk_col_q;   // Top-left corner of block
    logic [1:0]       elem_q;                 // TL, TR, BL, BR

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            blk_row_q <= '0;
            blk_col_q <= '0;
            elem_q    <= 2'd0;
        end else if (step_block_i) begin
            elem_q <= 2'd0;
            // Last block column sits at W, next would be W+2
            if (blk_col_q == width_i) begin
                blk_col_q <= '0;
                blk_row_q <= blk_row_q + DIM_W'(2);
            end else begin
                blk_col_q <= blk_col_q + DIM_W'(2);
            end
        end else if (step_elem_i) begin
            elem_q <= elem_q + 2'd1;   // Wraps to 0 after BR
        end
    end

    // Row bit is elem[1], column bit is elem[0]
    assign out_row_o  = blk_row_q + DIM_W'(elem_q[1]);
    assign out_col_o  = blk_col_q + DIM_W'(elem_q[0]);
    assign elem_idx_o = elem_q;

    assign last_elem_o  = (elem_q == 2'd3);
    assign last_block_o = (blk_row_q == width_i) && (blk_col_q == width_i);

endmodule

// File: source/mirror_addr_gen.sv
// Job settings latch and address generation for mirror padding
// m(0)=1, m(W+1)=W-2, else m(k)=k-1; addresses are combinational from coords
`timescale 1ns/100ps

module mirror_addr_gen #(
    parameter int DIM_W = 6
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_i,
    input  logic [pad_dma_pkg::ADDR_W-1:0] src_addr_i,
    input  logic [pad_dma_pkg::ADDR_W-1:0] dst_addr_i,
    input  logic [DIM_W-1:0]               mat_width_i,
    input  logic [DIM_W-1:0]               out_row_i,
    input  logic [DIM_W-1:0]               out_col_i,
    output logic [DIM_W-1:0]               width_o,
    output logic [pad_dma_pkg::ADDR_W-1:0] rd_addr_o,
    output logic [pad_dma_pkg::ADDR_W-1:0] wr_addr_o
);

    localparam int AW = pad_dma_pkg::ADDR_W;

    logic [AW-1:0]    src_base_q, dst_base_q;
    logic [DIM_W-1:0] width_q;
    logic [DIM_W-1:0] m_row, m_col;
    logic [AW-1:0]    src_word, dst_word;   // Word offsets

    function automatic logic [DIM_W-1:0] mirror_idx(input logic [DIM_W-1:0] k,
                                                    input logic [DIM_W-1:0] w);
        if (k == '0)
            return DIM_W'(1);
        else if (k == w + DIM_W'(1))
            return w - DIM_W'(2);           // Bottom/right border
        else
            return k - DIM_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n)
            width_q <= '0;
        else if (load_i)
            width_q <= mat_width_i;
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            src_base_q <= src_addr_i;
            dst_base_q <= dst_addr_i;
        end
    end

    assign m_row = mirror_idx(out_row_i, width_q);
    assign m_col = mirror_idx(out_col_i, width_q);

    assign src_word = AW'(m_row) * AW'(width_q) + AW'(m_col);
    assign dst_word = AW'(out_row_i) * (AW'(width_q) + AW'(2)) + AW'(out_col_i);

    assign rd_addr_o = src_base_q + src_word * AW'(pad_dma_pkg::BEAT_BYTES);
    assign wr_addr_o = dst_base_q + dst_word * AW'(pad_dma_pkg::BEAT_BYTES);
    assign width_o   = width_q;

endmodule

// File: source/beat_engine.sv
// Single-beat AXI read and write sequencer with a four-word block buffer
// Only one of rd_go_i / wr_go_i may be issued at a time; responses ignored
`timescale 1ns/100ps

module beat_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_go_i,
    input  logic                           wr_go_i,
    input  logic [1:0]                     elem_idx_i,
    input  logic [pad_dma_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic [pad_dma_pkg::ADDR_W-1:0] wr_addr_i,
    input  pad_dma_pkg::rbeat_t            r_i,
    input  logic                           arready_i,
    input  logic                           awready_i,
    input  logic                           wready_i,
    input  logic                           bvalid_i,
    output pad_dma_pkg::addr_req_t         ar_o,
    output pad_dma_pkg::addr_req_t         aw_o,
    output pad_dma_pkg::wbeat_t            w_o,
    output logic                           rready_o,
    output logic                           bready_o,
    output logic                           rd_done_o,
    output logic                           wr_done_o
);

    logic                           arvalid_q, awvalid_q, wvalid_q, wlast_q;
    logic                           rready_q, bready_q;
    logic [pad_dma_pkg::ADDR_W-1:0] araddr_q, awaddr_q;
    logic [pad_dma_pkg::DATA_W-1:0] wdata_q;
    logic [pad_dma_pkg::DATA_W-1:0] blk_buf_q [4];   // TL, TR, BL, BR
    logic                           aw_hs, w_hs;

    assign aw_hs     = awvalid_q && awready_i;
    assign w_hs      = wvalid_q && wready_i;
    assign rd_done_o = r_i.valid && rready_q;
    assign wr_done_o = bvalid_i && bready_q;

    // Valid and ready control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            wlast_q   <= 1'b0;
            bready_q  <= 1'b0;
        end else begin
            if (rd_go_i) begin
                arvalid_q <= 1'b1;
                rready_q  <= 1'b1;   // Rises with the request
            end
            if (arvalid_q && arready_i)
                arvalid_q <= 1'b0;
            if (rd_done_o)
                rready_q <= 1'b0;

            if (wr_go_i) begin
                awvalid_q <= 1'b1;
                bready_q  <= 1'b1;
            end
            if (aw_hs) begin
                awvalid_q <= 1'b0;
                wvalid_q  <= 1'b1;   // Data only after AW accepted
                wlast_q   <= 1'b1;
            end
            if (w_hs) begin
                wvalid_q <= 1'b0;
                wlast_q  <= 1'b0;
            end
            if (wr_done_o)
                bready_q <= 1'b0;
        end
    end

    // Payload, held stable while valid is up
    always_ff @(posedge clk) begin
        if (rd_go_i)
            araddr_q <= rd_addr_i;
        if (wr_go_i)
            awaddr_q <= wr_addr_i;
        if (aw_hs)
            wdata_q <= blk_buf_q[elem_idx_i];
        if (rd_done_o)
            blk_buf_q[elem_idx_i] <= r_i.data;
    end

    assign ar_o     = '{valid: arvalid_q, addr: araddr_q};
    assign aw_o     = '{valid: awvalid_q, addr: awaddr_q};
    assign w_o      = '{valid: wvalid_q, data: wdata_q, last: wlast_q};
    assign rready_o = rready_q;
    assign bready_o = bready_q;

endmodule

// File: source/pad_dma_top.sv
// Mirror padding DMA, W x W source words into (W+2) x (W+2) destination
// W must be even, 4 <= W <= 2**DIM_W - 2; inputs sampled when start_i seen idle
// Single-beat AXI, one transaction in flight; response codes are ignored
`timescale 1ns/100ps

module pad_dma_top #(
    parameter int DIM_W = pad_dma_pkg::DIM_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [pad_dma_pkg::ADDR_W-1:0]  src_addr_i,
    input  logic [pad_dma_pkg::ADDR_W-1:0]  dst_addr_i,
    input  logic [DIM_W-1:0]                mat_width_i,
    input  logic                            start_i,
    output logic                            done_o,
    // AW channel
    output logic [pad_dma_pkg::ADDR_W-1:0]  awaddr_o,
    output logic [3:0]                      awlen_o,
    output logic [2:0]                      awsize_o,
    output logic [1:0]                      awburst_o,
    output logic                            awvalid_o,
    input  logic                            awready_i,
    // W channel
    output logic [pad_dma_pkg::DATA_W-1:0]  wdata_o,
    output logic [3:0]                      wstrb_o,
    output logic                            wlast_o,
    output logic                            wvalid_o,
    input  logic                            wready_i,
    // B channel
    input  logic                            bvalid_i,
    output logic                            bready_o,
    // AR channel
    output logic [pad_dma_pkg::ADDR_W-1:0]  araddr_o,
    output logic [3:0]                      arlen_o,
    output logic [2:0]                      arsize_o,
    output logic [1:0]                      arburst_o,
    output logic                            arvalid_o,
    input  logic                            arready_i,
    // R channel
    input  logic [pad_dma_pkg::DATA_W-1:0]  rdata_i,
    input  logic                            rvalid_i,
    output logic                            rready_o
);

    logic                           clear, load, step_elem, step_block;
    logic                           rd_go, wr_go, rd_done, wr_done;
    logic                           last_elem, last_block;
    logic [DIM_W-1:0]               width, out_row, out_col;
    logic [1:0]                     elem_idx;
    logic [pad_dma_pkg::ADDR_W-1:0] rd_addr, wr_addr;
    pad_dma_pkg::addr_req_t         ar, aw;
    pad_dma_pkg::wbeat_t            w;
    pad_dma_pkg::rbeat_t            r;

    assign r = '{valid: rvalid_i, data: rdata_i};

    assign araddr_o  = ar.addr;
    assign arvalid_o = ar.valid;
    assign arlen_o   = pad_dma_pkg::AXI_LEN_SINGLE;
    assign arsize_o  = pad_dma_pkg::AXI_SIZE_WORD;
    assign arburst_o = pad_dma_pkg::AXI_BURST_INCR;

    assign awaddr_o  = aw.addr;
    assign awvalid_o = aw.valid;
    assign awlen_o   = pad_dma_pkg::AXI_LEN_SINGLE;
    assign awsize_o  = pad_dma_pkg::AXI_SIZE_WORD;
    assign awburst_o = pad_dma_pkg::AXI_BURST_INCR;

    assign wdata_o   = w.data;
    assign wlast_o   = w.last;
    assign wvalid_o  = w.valid;
    assign wstrb_o   = pad_dma_pkg::AXI_STRB_ALL;

    pad_dma_fsm u_fsm (
        .clk, .rst_n, .start_i,
        .last_elem_i (last_elem),   .last_block_i (last_block),
        .rd_done_i   (rd_done),     .wr_done_i    (wr_done),
        .done_o,
        .clear_o     (clear),       .load_o       (load),
        .step_elem_o (step_elem),   .step_block_o (step_block),
        .rd_go_o     (rd_go),       .wr_go_o      (wr_go)
    );

    block_walker #(.DIM_W(DIM_W)) u_walker (
        .clk, .rst_n,
        .width_i      (width),      .clear_i      (clear),
        .step_elem_i  (step_elem),  .step_block_i (step_block),
        .out_row_o    (out_row),    .out_col_o    (out_col),
        .elem_idx_o   (elem_idx),
        .last_elem_o  (last_elem),  .last_block_o (last_block)
    );

    mirror_addr_gen #(.DIM_W(DIM_W)) u_addr (
        .clk, .rst_n,
        .load_i    (load),
        .src_addr_i, .dst_addr_i, .mat_width_i,
        .out_row_i (out_row),       .out_col_i    (out_col),
        .width_o   (width),
        .rd_addr_o (rd_addr),       .wr_addr_o    (wr_addr)
    );

    beat_engine u_beat (
        .clk, .rst_n,
        .rd_go_i    (rd_go),        .wr_go_i      (wr_go),
        .elem_idx_i (elem_idx),
        .rd_addr_i  (rd_addr),      .wr_addr_i    (wr_addr),
        .r_i        (r),
        .arready_i, .awready_i, .wready_i, .bvalid_i,
        .ar_o       (ar),           .aw_o         (aw),
        .w_o        (w),
        .rready_o, .bready_o,
        .rd_done_o  (rd_done),      .wr_done_o    (wr_done)
    );

endmodule

// File: test/pad_dma_tb.sv
// Drives three padding jobs through an AXI memory model with random back-pressure
// Read data is a hash of the byte address, so each write shows which word was copied
// Destination words are tracked up to a padded width of 16
`timescale 1ns/100ps

module pad_dma_tb;

    localparam int DIM_W       = pad_dma_pkg::DIM_W_DEFAULT;
    localparam int W_MAX       = 12;
    localparam int NUM_JOBS    = 3;
    localparam int CYCLE_LIMIT = NUM_JOBS * 400 * (W_MAX + 2) * (W_MAX + 2);

    logic             clk, rst_n, start_i, done_o;
    logic [31:0]      src_addr_i, dst_addr_i;
    logic [DIM_W-1:0] mat_width_i;
    logic [31:0]      awaddr_o, wdata_o, araddr_o, rdata_i;
    logic [3:0]       awlen_o, arlen_o, wstrb_o;
    logic [2:0]       awsize_o, arsize_o;
    logic [1:0]       awburst_o, arburst_o;
    logic             awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
    logic             bvalid_i, bready_o, arvalid_o, arready_i, rvalid_i, rready_o;

    logic [31:0] job_src, job_dst, rd_addr_q, aw_addr_q;
    int          job_w, rd_wait, b_wait, errors, reads, write_count, writes_total;
    int          cycles, seed, prop_fails;
    bit          written [256];   // One flag per destination word

    pad_dma_top #(.DIM_W(DIM_W)) pad_dma_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Mirror rule, one axis
    function automatic int src_index(input int k, input int w);
        if (k == 0)
            return 1;
        if (k == w + 1)
            return w - 2;
        return k - 1;
    endfunction

    function automatic logic [31:0] addr_hash(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ (a >> 13) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        errors++;
    endtask

    // Single-beat word INCR: len 0, size 2 (4 bytes), burst 01
    task automatic check_attrs(input string chan, input logic [3:0] len,
                               input logic [2:0] size, input logic [1:0] burst);
        assert (len == 4'd0 && size == 3'd2 && burst == 2'b01)
        else report_error($sformatf("%s len %0d size %0d burst %0d, expected 0 2 1",
                                    chan, len, size, burst));
    endtask

    task automatic check_read(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - job_src;
        reads++;
        assert (offs[1:0] == 2'b00 && offs / 4 < job_w * job_w)
        else report_error($sformatf("read address %h outside the source matrix", addr));
    endtask

    task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] offs, expected;
        int          dim, idx, r, c;
        bit          in_range;
        dim = job_w + 2;
        offs = addr - job_dst;
        in_range = (offs[1:0] == 2'b00) && (offs / 4 < dim * dim);
        assert (in_range) else report_error($sformatf("write address %h out of range", addr));
        if (in_range) begin
            idx = offs / 4;
            r = idx / dim;
            c = idx % dim;
            expected = addr_hash(job_src + (src_index(r, job_w) * job_w + src_index(c, job_w)) * 4);
            assert (data == expected)
            else report_error($sformatf("(%0d,%0d) got %h, expected %h", r, c, data, expected));
            assert (!written[idx]) else report_error($sformatf("(%0d,%0d) written twice", r, c));
            written[idx] = 1'b1;
            write_count++;
            writes_total++;
        end
    endtask

    // Memory model, ready and response timing drawn at random
    always @(posedge clk) begin
        if (!rst_n) begin
            arready_i <= 1'b0;
            awready_i <= 1'b0;
            wready_i  <= 1'b0;
            rvalid_i  <= 1'b0;
            bvalid_i  <= 1'b0;
            rd_wait = -1;
            b_wait  = -1;
        end else begin
            arready_i <= ($urandom % 4) != 0;
            awready_i <= ($urandom % 4) != 0;
            wready_i  <= ($urandom % 3) != 0;
            if (arvalid_o && arready_i) begin
                check_read(araddr_o);
                check_attrs("AR", arlen_o, arsize_o, arburst_o);
                rd_addr_q = araddr_o;
                rd_wait = $urandom % 4;
            end
            if (rvalid_i && rready_o)
                rvalid_i <= 1'b0;
            if (rd_wait == 0) begin
                rvalid_i <= 1'b1;
                rdata_i  <= addr_hash(rd_addr_q);
            end
            if (rd_wait >= 0)
                rd_wait--;
            if (awvalid_o && awready_i) begin
                check_attrs("AW", awlen_o, awsize_o, awburst_o);
                aw_addr_q = awaddr_o;
            end
            if (wvalid_o && wready_i) begin
                assert (wlast_o && wstrb_o == 4'hf)
                else report_error($sformatf("W last %b strb %h, expected 1 f", wlast_o, wstrb_o));
                check_write(aw_addr_q, wdata_o);
                b_wait = $urandom % 4;
            end
            if (bvalid_i && bready_o)
                bvalid_i <= 1'b0;
            if (b_wait == 0)
                bvalid_i <= 1'b1;
            if (b_wait >= 0)
                b_wait--;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    task automatic run_job(input int num, input logic [31:0] src, input logic [31:0] dst,
                           input int w);
        int errors_before;
        errors_before = errors;
        job_src = src;
        job_dst = dst;
        job_w = w;
        written = '{default: 1'b0};
        write_count = 0;
        @(posedge clk);
        src_addr_i  <= src;
        dst_addr_i  <= dst;
        mat_width_i <= DIM_W'(w);
        start_i     <= 1'b1;
        repeat (2) @(posedge clk);
        assert (!done_o) else report_error("done_o still high after start");
        while (!done_o)
            @(posedge clk);
        assert (write_count == (w + 2) * (w + 2))
        else report_error($sformatf("%0d words written, expected %0d", write_count, (w + 2) ** 2));
        // Start held high, engine must stay finished
        repeat (6) begin
            @(posedge clk);
            assert (done_o && !arvalid_o) else report_error("job restarted while start_i held");
        end
        start_i <= 1'b0;
        repeat (2) @(posedge clk);
        if (errors == errors_before)
            $display("job %0d (W=%0d) passed, %0d words", num, w, write_count);
        else
            $display("job %0d (W=%0d) failed, %0d mismatches", num, w, errors - errors_before);
    endtask

    initial begin
        seed = $urandom(32'he4f1b1ba);
        cycles = 0;
        rst_n = 1'b0;
        start_i = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        mat_width_i = '0;
        arready_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        rvalid_i = 1'b0;
        bvalid_i = 1'b0;
        rdata_i = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        run_job(1, 32'h0000_1000, 32'h0010_0000, 4);
        run_job(2, 32'h0002_0040, 32'h0020_0100, 6);
        run_job(3, 32'h0003_0000, 32'h0030_0000, 2 * $urandom_range(6, 2));
        prop_fails = pad_dma_top_i.u_props.fail_count;
        $display("%0d jobs, %0d reads, %0d writes checked, %0d mismatches, %0d property failures",
                 NUM_JOBS, reads, writes_total, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: test/pad_dma_properties.sv
// AXI request rules and reset state, bound onto pad_dma_top
// Assumes single-beat transfers with one request in flight
`timescale 1ns/100ps

module pad_dma_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        done_i,
    input logic        arvalid_i,
    input logic        arready_i,
    input logic [31:0] araddr_i,
    input logic        awvalid_i,
    input logic        awready_i,
    input logic [31:0] awaddr_i,
    input logic        wvalid_i,
    input logic        wready_i,
    input logic [31:0] wdata_i,
    input logic        rready_i,
    input logic        bready_i
);

    int fail_count = 0;

    // Outputs idle one cycle after a reset edge
    reset_idle: assert property (@(posedge clk) !rst_n |=> done_i && !arvalid_i &&
                                 !awvalid_i && !wvalid_i && !rready_i && !bready_i)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else begin
        $error("AR request changed before arready");
        fail_count++;
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else begin
        $error("AW request changed before awready");
        fail_count++;
    end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else begin
        $error("W beat changed before wready");
        fail_count++;
    end

    // Nothing in flight once the job reports done
    done_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                $rose(done_i) |-> !arvalid_i && !awvalid_i && !wvalid_i &&
                                !rready_i && !bready_i)
    else begin
        $error("done rose with a transfer pending");
        fail_count++;
    end

endmodule

bind pad_dma_top pad_dma_properties u_props (
    .clk,
    .rst_n,
    .done_i    (done_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .araddr_i  (araddr_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .awaddr_i  (awaddr_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_i   (wdata_o),
    .rready_i  (rready_o),
    .bready_i  (bready_o)
);

// File: list.f
source/pad_dma_pkg.sv
source/pad_dma_fsm.sv
source/block_walker.sv
source/mirror_addr_gen.sv
source/beat_engine.sv
source/pad_dma_top.sv
test/pad_dma_tb.sv
test/pad_dma_properties.sv
